// ==== cmd_path/cmd_tx.sv ====
`timescale 1ns/1ps

module cmd_tx import sd_pkg::*; (
    input  logic        clk_fast,
    input  logic        rst_n,
    input  logic        cmd_start,
    input  sd_cmd_req_t cmd_req,
    input  logic        busy,
    output logic        sd_cmd_out,
    output logic        sd_cmd_oe,
    output logic        cmd_done,
    output logic        rx_arm,
    output resp_type_e  rx_type
);

    tx_state_e state;
    logic [cmd_content_bits-1:0] shift_q;
    logic [$clog2(cmd_frame_bits)-1:0] bit_cnt;
    logic crc_shift;
    logic crc_bit;
    crc7_t crc;

    // ========================================
    // Frame content register
    // ========================================
    // Request capture stays open while the controller is idle
    always_ff @(posedge clk_fast) begin
        if (!busy) begin
            shift_q <= {1'b0, 1'b1, cmd_req.index, cmd_req.arg};
            rx_type <= cmd_req.resp_type;
        end else if (state == tx_content) begin
            shift_q <= {shift_q[cmd_content_bits-2:0], 1'b0};
        end
    end

    // ========================================
    // Serializer FSM
    // ========================================
    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            state    <= tx_idle;
            bit_cnt  <= '0;
            cmd_done <= 1'b0;
            rx_arm   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            rx_arm   <= 1'b0;
            case (state)
                tx_idle: begin
                    if (cmd_start) begin
                        state   <= tx_content;
                        bit_cnt <= '0;
                    end
                end
                tx_content: begin
                    if (bit_cnt == cmd_content_bits - 1) begin
                        state   <= tx_crc;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_crc: begin
                    if (bit_cnt == crc7_bits - 1) begin
                        state <= tx_end;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_end: begin
                    state    <= tx_idle;
                    cmd_done <= 1'b1;
                    rx_arm   <= (rx_type != resp_none);
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // Feeding the CRC MSB back in turns the LFSR into a plain shifter
    assign crc_shift = (state == tx_content) || (state == tx_crc);
    assign crc_bit   = (state == tx_content) ? shift_q[cmd_content_bits-1] : crc[crc7_bits-1];

    crc7 u_crc7 (
        .clk_fast (clk_fast),
        .rst_n    (rst_n),
        .clear    (cmd_start),
        .shift_en (crc_shift),
        .bit_in   (crc_bit),
        .crc      (crc)
    );

    // CMD line drive, idles high
    assign sd_cmd_oe = (state != tx_idle);

    always_comb begin
        case (state)
            tx_content: sd_cmd_out = shift_q[cmd_content_bits-1];
            tx_crc:     sd_cmd_out = crc[crc7_bits-1];
            default:    sd_cmd_out = 1'b1;
        endcase
    end

endmodule

// ==== cmd_path/resp_rx.sv ====
`timescale 1ns/1ps

module resp_rx import sd_pkg::*; (
    input  logic       clk_fast,
    input  logic       rst_n,
    input  logic       rx_arm,
    input  resp_type_e rx_type,
    input  logic       sd_cmd_in,
    output logic       resp_valid,
    output sd_resp_t   resp
);

    rx_state_e state;
    resp_type_e type_q;
    logic [resp136_bits-1:0] shift_q;
    logic [$clog2(resp136_bits)-1:0] bit_cnt;
    logic [$clog2(turnaround_cycles+1)-1:0] ta_cnt;
    logic sample;
    logic last_bit;
    logic crc_cover;
    crc7_t crc;

    // Start bit counts as the first sampled bit
    assign sample = ((state == rx_wait_start) && !sd_cmd_in) || (state == rx_shift);

    always_comb begin
        if (type_q == resp_136) begin
            last_bit  = (bit_cnt == resp136_bits - 1);
            // R2 CRC skips the leading header byte
            crc_cover = (bit_cnt >= resp_crc_skip_bits) &&
                        (bit_cnt < resp136_bits - crc7_bits - 1);
        end else begin
            last_bit  = (bit_cnt == resp48_bits - 1);
            crc_cover = (bit_cnt < resp48_bits - crc7_bits - 1);
        end
    end

    // ========================================
    // Receiver FSM
    // ========================================
    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            state      <= rx_idle;
            type_q     <= resp_none;
            bit_cnt    <= '0;
            ta_cnt     <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    if (rx_arm) begin
                        state   <= rx_turnaround;
                        type_q  <= rx_type;
                        ta_cnt  <= '0;
                        bit_cnt <= '0;
                    end
                end
                rx_turnaround: begin
                    // Line may still float while the card takes over
                    if (ta_cnt == turnaround_cycles - 1) begin
                        state <= rx_wait_start;
                    end else begin
                        ta_cnt <= ta_cnt + 1'b1;
                    end
                end
                rx_wait_start: begin
                    if (!sd_cmd_in) begin
                        state   <= rx_shift;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_shift: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        state <= rx_check;
                    end
                end
                rx_check: begin
                    state      <= rx_idle;
                    resp_valid <= 1'b1;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Frame lands MSB first, end bit ends up in bit 0
    always_ff @(posedge clk_fast) begin
        if (sample) begin
            shift_q <= {shift_q[resp136_bits-2:0], sd_cmd_in};
        end
    end

    crc7 u_crc7 (
        .clk_fast (clk_fast),
        .rst_n    (rst_n),
        .clear    (rx_arm),
        .shift_en (sample && crc_cover),
        .bit_in   (sd_cmd_in),
        .crc      (crc)
    );

    // ========================================
    // Response decode
    // ========================================
    always_ff @(posedge clk_fast) begin
        if (state == rx_check) begin
            resp.crc_err <= (crc != shift_q[crc7_bits:1]) || !shift_q[0];
            if (type_q == resp_136) begin
                // Index field is reserved in R2, passed as received
                resp.index <= shift_q[133:128];
                resp.data  <= shift_q[resp136_bits-resp_crc_skip_bits-1:crc7_bits+1];
            end else begin
                resp.index <= shift_q[45:40];
                resp.data  <= resp_data_t'(shift_q[39:8]);
            end
        end
    end

endmodule

// ==== common/sd_pkg.sv ====
package sd_pkg;

    // ========================================
    // Frame lengths
    // ========================================
    localparam int cmd_frame_bits     = 48;
    localparam int cmd_content_bits   = 40;
    localparam int crc7_bits          = 7;
    localparam int resp48_bits        = 48;
    localparam int resp136_bits       = 136;
    // Start, transmission and reserved bits ahead of the R2 CRC span
    localparam int resp_crc_skip_bits = 8;
    // Line handover from host to card after the end bit
    localparam int turnaround_cycles  = 2;

    // ========================================
    // Field types
    // ========================================
    typedef logic [5:0]   cmd_index_t;
    typedef logic [31:0]  cmd_arg_t;
    typedef logic [6:0]   crc7_t;
    typedef logic [119:0] resp_data_t;

    typedef enum logic [1:0] {
        resp_none,
        resp_48,
        resp_136
    } resp_type_e;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
        resp_type_e resp_type;
    } sd_cmd_req_t;

    // R1/R3/R6/R7 data sits zero-extended in the low 32 bits
    typedef struct packed {
        cmd_index_t index;
        resp_data_t data;
        logic       crc_err;
    } sd_resp_t;

    // ========================================
    // State machines
    // ========================================
    typedef enum logic [1:0] {
        tx_idle,
        tx_content,
        tx_crc,
        tx_end
    } tx_state_e;

    typedef enum logic [2:0] {
        rx_idle,
        rx_turnaround,
        rx_wait_start,
        rx_shift,
        rx_check
    } rx_state_e;

endpackage

// ==== logic/crc7.sv ====
`timescale 1ns/1ps

module crc7 import sd_pkg::*; (
    input  logic  clk_fast,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  shift_en,
    input  logic  bit_in,
    output crc7_t crc
);

    logic feedback;

    // Polynomial x^7 + x^3 + 1
    assign feedback = bit_in ^ crc[crc7_bits-1];

    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift_en) begin
            // Shift left, feedback enters at bit 0 and taps bit 3
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

// ==== logic/sd_cmd_ctrl.sv ====
`timescale 1ns/1ps

module sd_cmd_ctrl import sd_pkg::*; (
    input  logic        clk_fast,
    input  logic        rst_n,
    input  logic        cmd_start,
    input  sd_cmd_req_t cmd_req,
    output logic        cmd_done,
    output logic        busy,
    output logic        sd_cmd_out,
    output logic        sd_cmd_oe,
    input  logic        sd_cmd_in,
    output logic        resp_valid,
    output sd_resp_t    resp
);

    logic cmd_go;
    logic rx_arm;
    resp_type_e rx_type;

    // ========================================
    // Busy tracking
    // ========================================
    // Only one command in flight, later starts are dropped
    assign cmd_go = cmd_start && !busy;

    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (cmd_go) begin
            busy <= 1'b1;
        end else if ((cmd_done && !rx_arm) || resp_valid) begin
            busy <= 1'b0;
        end
    end

    // ========================================
    // Command and response paths
    // ========================================
    cmd_tx u_cmd_tx (
        .clk_fast   (clk_fast),
        .rst_n      (rst_n),
        .cmd_start  (cmd_go),
        .cmd_req    (cmd_req),
        .busy       (busy),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .cmd_done   (cmd_done),
        .rx_arm     (rx_arm),
        .rx_type    (rx_type)
    );

    // Armed by the serializer once the end bit is out
    resp_rx u_resp_rx (
        .clk_fast   (clk_fast),
        .rst_n      (rst_n),
        .rx_arm     (rx_arm),
        .rx_type    (rx_type),
        .sd_cmd_in  (sd_cmd_in),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sd_cmd_ctrl.f \
    --top-module tb_sd_cmd_ctrl -o tb_sd_cmd_ctrl \
    && ./obj_dir/tb_sd_cmd_ctrl +verilator+error+limit+100 > sim.log 2>&1
grep -qx "All checks passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sd_cmd_ctrl.f ====
common/sd_pkg.sv
logic/crc7.sv
cmd_path/cmd_tx.sv
cmd_path/resp_rx.sv
logic/sd_cmd_ctrl.sv
sim/sd_cmd_chk.sv
sim/tb_sd_cmd_ctrl.sv

// ==== sim/sd_cmd_chk.sv ====
`timescale 1ns/1ps

module sd_cmd_chk import sd_pkg::*; (
    input logic clk_fast,
    input logic rst_n,
    input logic sd_cmd_oe,
    input logic sd_cmd_out,
    input logic cmd_done,
    input logic resp_valid
);

    int oe_len;
    int fail_cnt = 0;

    // Cycles spent in the current CMD drive window
    always_ff @(posedge clk_fast) begin
        if (!rst_n || !sd_cmd_oe) begin
            oe_len <= 0;
        end else begin
            oe_len <= oe_len + 1;
        end
    end

    a_oe_max: assert property (@(posedge clk_fast) disable iff (!rst_n)
        sd_cmd_oe |-> (oe_len < cmd_frame_bits))
    else begin
        fail_cnt++;
        $error("sd_cmd_oe held longer than %0d cycles", cmd_frame_bits);
    end

    // Window closes only after one full frame
    a_oe_len: assert property (@(posedge clk_fast) disable iff (!rst_n)
        $fell(sd_cmd_oe) |-> (oe_len == cmd_frame_bits))
    else begin
        fail_cnt++;
        $error("sd_cmd_oe window of %0d cycles", oe_len);
    end

    a_done_resp: assert property (@(posedge clk_fast) disable iff (!rst_n)
        !(cmd_done && resp_valid))
    else begin
        fail_cnt++;
        $error("cmd_done and resp_valid high in the same cycle");
    end

    a_idle_high: assert property (@(posedge clk_fast) disable iff (!rst_n)
        !sd_cmd_oe |-> sd_cmd_out)
    else begin
        fail_cnt++;
        $error("sd_cmd_out low while the line is not driven");
    end

endmodule

bind sd_cmd_ctrl sd_cmd_chk u_chk (
    .clk_fast   (clk_fast),
    .rst_n      (rst_n),
    .sd_cmd_oe  (sd_cmd_oe),
    .sd_cmd_out (sd_cmd_out),
    .cmd_done   (cmd_done),
    .resp_valid (resp_valid)
);

// ==== sim/tb_sd_cmd_ctrl.sv ====
`timescale 1ns/1ps

module tb_sd_cmd_ctrl import sd_pkg::*; ();

    // Six tests of at most about 300 cycles each, wide margin on top
    localparam int max_cycles = 20000;

    logic        clk_fast = 1'b0;
    logic        rst_n;
    logic        cmd_start;
    sd_cmd_req_t cmd_req;
    logic        cmd_done;
    logic        busy;
    logic        sd_cmd_out;
    logic        sd_cmd_oe;
    logic        sd_cmd_in;
    logic        resp_valid;
    sd_resp_t    resp;

    logic [cmd_frame_bits-1:0] exp_frame_q[$];
    sd_resp_t exp_resp_q[$];
    logic tx_bits[$];
    logic oe_q = 1'b0;
    int   cycle_cnt = 0;
    int   errors = 0;
    int   tests_run = 0;
    int   frames_seen = 0;
    int   resps_seen = 0;

    sd_cmd_ctrl u_dut (
        .clk_fast   (clk_fast),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .cmd_req    (cmd_req),
        .cmd_done   (cmd_done),
        .busy       (busy),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #2 clk_fast = ~clk_fast;

    // ========================================
    // Reference model
    // ========================================
    // Bitwise CRC7 with x^7 + x^3 + 1, over bits n-1 down to 0
    function automatic crc7_t calc_crc7(input logic [resp136_bits-1:0] bits, input int n);
        crc7_t c;
        logic fb;
        c = '0;
        for (int i = n - 1; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    function automatic logic [cmd_frame_bits-1:0] cmd_frame(input cmd_index_t idx,
                                                           input cmd_arg_t arg);
        logic [cmd_content_bits-1:0] content;
        content = {1'b0, 1'b1, idx, arg};
        return {content, calc_crc7({96'b0, content}, cmd_content_bits), 1'b1};
    endfunction

    // Card responses carry a 0 transmission bit
    function automatic logic [resp48_bits-1:0] r48_frame(input cmd_index_t idx,
                                                        input cmd_arg_t arg);
        logic [39:0] content;
        content = {2'b00, idx, arg};
        return {content, calc_crc7({96'b0, content}, 40), 1'b1};
    endfunction

    function automatic logic [resp136_bits-1:0] r2_frame(input resp_data_t data);
        return {2'b00, 6'h3f, data, calc_crc7({16'b0, data}, 120), 1'b1};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        repeat (2) @(posedge clk_fast);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: FAIL", tests_run, name);
        end
    endtask

    task automatic start_cmd(input cmd_index_t idx, input cmd_arg_t arg, input resp_type_e rt);
        @(posedge clk_fast);
        cmd_start <= 1'b1;
        cmd_req   <= '{index: idx, arg: arg, resp_type: rt};
        @(posedge clk_fast);
        cmd_start <= 1'b0;
    endtask

    // Edges from the accepted start up to the one that sees cmd_done
    task automatic wait_cmd_done(output int n);
        n = 0;
        do begin
            @(posedge clk_fast);
            n++;
        end while (!cmd_done && n < 100);
        if (!cmd_done) begin
            $display("No cmd_done within 100 cycles of the command start");
            errors++;
        end
    endtask

    task automatic wait_resp_valid();
        int n;
        n = 0;
        do begin
            @(posedge clk_fast);
            n++;
        end while (!resp_valid && n < 300);
        if (!resp_valid) begin
            $display("No resp_valid within 300 cycles of the response");
            errors++;
        end
    endtask

    // Card model, response goes out MSB first after a random gap
    task automatic card_respond(input logic [resp136_bits-1:0] frame, input int nbits);
        int gap;
        gap = $urandom_range(20, 3);
        repeat (gap) @(posedge clk_fast);
        for (int i = nbits - 1; i >= 0; i--) begin
            @(posedge clk_fast);
            sd_cmd_in <= frame[i];
        end
        @(posedge clk_fast);
        sd_cmd_in <= 1'b1;
    endtask

    task automatic run_cmd_resp(input cmd_index_t idx, input cmd_arg_t arg,
                                input resp_type_e rt, input logic [resp136_bits-1:0] rsp,
                                input int nbits, input sd_resp_t exp);
        int n;
        int r0;
        r0 = resps_seen;
        exp_frame_q.push_back(cmd_frame(idx, arg));
        exp_resp_q.push_back(exp);
        start_cmd(idx, arg, rt);
        wait_cmd_done(n);
        card_respond(rsp, nbits);
        wait_resp_valid();
        @(posedge clk_fast);
        if (busy) begin
            report_mismatch("busy still high after resp_valid");
        end
        if (resps_seen != r0 + 1) begin
            report_mismatch($sformatf("%0d resp_valid pulses, expected 1", resps_seen - r0));
        end
    endtask

    // ========================================
    // Compare process
    // ========================================
    always @(posedge clk_fast) begin
        logic [cmd_frame_bits-1:0] got;
        logic [cmd_frame_bits-1:0] want;
        sd_resp_t exp;
        if (rst_n) begin
            if (sd_cmd_oe) begin
                tx_bits.push_back(sd_cmd_out);
            end else if (oe_q) begin
                frames_seen++;
                got = '0;
                foreach (tx_bits[i]) begin
                    got = {got[cmd_frame_bits-2:0], tx_bits[i]};
                end
                if (exp_frame_q.size() == 0) begin
                    report_mismatch($sformatf("unexpected command frame %h", got));
                end else begin
                    want = exp_frame_q.pop_front();
                    if (tx_bits.size() != cmd_frame_bits) begin
                        report_mismatch($sformatf("frame of %0d bits", tx_bits.size()));
                    end else if (got !== want) begin
                        report_mismatch($sformatf("frame %h, expected %h", got, want));
                    end
                end
                tx_bits.delete();
            end
            oe_q = sd_cmd_oe;
            if (resp_valid) begin
                resps_seen++;
                if (exp_resp_q.size() == 0) begin
                    report_mismatch("resp_valid with no response expected");
                end else begin
                    exp = exp_resp_q.pop_front();
                    if (resp.index !== exp.index || resp.data !== exp.data) begin
                        report_mismatch($sformatf("resp %h/%h, expected %h/%h",
                            resp.index, resp.data, exp.index, exp.data));
                    end
                    if (resp.crc_err !== exp.crc_err) begin
                        report_mismatch($sformatf("crc_err %b, expected %b",
                            resp.crc_err, exp.crc_err));
                    end
                end
            end
        end
    end

    always @(posedge clk_fast) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        int n;
        int e0;
        int f0;
        int r0;
        cmd_index_t idx;
        cmd_arg_t arg;
        resp_data_t r2_data;
        logic [resp136_bits-1:0] rsp;
        sd_resp_t exp;

        n = $urandom(32'h5468_0aa2);
        rst_n     = 1'b0;
        cmd_start = 1'b0;
        cmd_req   = '0;
        sd_cmd_in = 1'b1;
        repeat (16) @(posedge clk_fast);
        rst_n <= 1'b1;

        e0 = errors;
        @(posedge clk_fast);
        if (sd_cmd_oe !== 1'b0 || sd_cmd_out !== 1'b1) begin
            report_mismatch("CMD line not released after reset");
        end
        if (busy !== 1'b0 || cmd_done !== 1'b0 || resp_valid !== 1'b0) begin
            report_mismatch("status outputs not cleared after reset");
        end
        finish_test("reset state", e0);

        e0 = errors;
        repeat (3) begin
            idx = 6'($urandom);
            arg = $urandom;
            exp_frame_q.push_back(cmd_frame(idx, arg));
            start_cmd(idx, arg, resp_none);
            wait_cmd_done(n);
            if (n != 49) begin
                report_mismatch($sformatf("cmd_done after %0d cycles, expected 49", n));
            end
            @(posedge clk_fast);
        end
        finish_test("command frame and CRC7", e0);

        e0 = errors;
        idx = 6'd17;
        arg = $urandom;
        rsp = {88'b0, r48_frame(idx, arg)};
        exp = '{index: idx, data: resp_data_t'(arg), crc_err: 1'b0};
        run_cmd_resp(idx, arg, resp_48, rsp, resp48_bits, exp);
        finish_test("48-bit response", e0);

        e0 = errors;
        r2_data = {$urandom, $urandom, $urandom, 24'($urandom)};
        exp = '{index: 6'h3f, data: r2_data, crc_err: 1'b0};
        run_cmd_resp(6'd2, 32'h0, resp_136, r2_frame(r2_data), resp136_bits, exp);
        finish_test("136-bit response", e0);

        e0 = errors;
        idx = 6'd13;
        arg = $urandom;
        rsp = {88'b0, r48_frame(idx, arg)};
        n = $urandom_range(7, 1);
        rsp[n] = ~rsp[n];
        exp = '{index: idx, data: resp_data_t'(arg), crc_err: 1'b1};
        run_cmd_resp(idx, arg, resp_48, rsp, resp48_bits, exp);
        rsp = {88'b0, r48_frame(idx, arg)};
        rsp[0] = 1'b0;
        run_cmd_resp(idx, arg, resp_48, rsp, resp48_bits, exp);
        finish_test("CRC and end bit errors", e0);

        e0 = errors;
        f0 = frames_seen;
        r0 = resps_seen;
        idx = 6'($urandom);
        arg = $urandom;
        exp_frame_q.push_back(cmd_frame(idx, arg));
        start_cmd(idx, arg, resp_none);
        wait_cmd_done(n);
        @(posedge clk_fast);
        if (busy) begin
            report_mismatch("busy still high after a command without response");
        end
        repeat (200) @(posedge clk_fast);
        if (resps_seen != r0) begin
            report_mismatch("resp_valid for a command without response");
        end
        idx = 6'd55;
        arg = $urandom;
        rsp = {88'b0, r48_frame(idx, arg)};
        exp = '{index: idx, data: resp_data_t'(arg), crc_err: 1'b0};
        exp_frame_q.push_back(cmd_frame(idx, arg));
        exp_resp_q.push_back(exp);
        start_cmd(idx, arg, resp_48);
        wait_cmd_done(n);
        // Serializer is idle again while busy waits for the response
        start_cmd(~idx, ~arg, resp_48);
        card_respond(rsp, resp48_bits);
        wait_resp_valid();
        @(posedge clk_fast);
        if (busy) begin
            report_mismatch("busy still high after resp_valid");
        end
        if (frames_seen != f0 + 2) begin
            report_mismatch($sformatf("%0d frames sent, expected 2", frames_seen - f0));
        end
        finish_test("no response and start while busy", e0);

        $display("Tests: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, errors, u_dut.u_chk.fail_cnt);
        if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
